//--- common/iagc_settings.svh
`ifndef IAGC_SETTINGS_SVH
`define IAGC_SETTINGS_SVH

`define IAGC_ADC_W          14  // raw adc word width.
`define IAGC_SAMPLE_W       16  // widened sample width.
`define IAGC_MEM_DEPTH      64  // words in the sample memory.
`define IAGC_ADDR_W         6   // sample memory address width.

`define IAGC_DEF_DECIMATOR  3   // strobe every 4 clocks after reset.
`define IAGC_DEF_MEM_PARAM  3   // 16 words after reset.
`define IAGC_AMP_WINDOW     16  // decimated samples per peak window.

`define IAGC_CLKS_PER_BIT   16  // system clocks per uart bit.

`endif

//--- common/iagc_pkg.sv
package iagc_pkg;

`include "iagc_settings.svh"

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CAPTURE,
        ST_DUMP,
        ST_LOG
    } iagc_state_t;

    typedef enum logic [3:0] {
        OP_SET_DECIMATOR = 4'd1,
        OP_SET_LENGTH    = 4'd2,
        OP_CAPTURE       = 4'd3,
        OP_DUMP          = 4'd4,
        OP_LOG           = 4'd5
    } cmd_op_t;

    // One command byte from the host.
    typedef struct packed {
        cmd_op_t    op;     // values outside the list are ignored.
        logic [3:0] param;
    } cmd_t;

    typedef struct packed {
        logic signed [`IAGC_SAMPLE_W-1:0] ref_sample;   // channel 1.
        logic signed [`IAGC_SAMPLE_W-1:0] err_sample;   // channel 2.
    } sample_pair_t;

    typedef struct packed {
        logic [3:0]            decimator;
        logic [`IAGC_ADDR_W:0] length;      // capture length in words.
    } iagc_cfg_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } tx_req_t;

endpackage

//--- uart/uart_rx.sv
`timescale 1ns/1ns

`include "iagc_settings.svh"

module uart_rx (
    input  logic            i_clock,
    input  logic            i_arst_n,
    input  logic            i_rx,
    output iagc_pkg::cmd_t  o_cmd,
    output logic            o_valid
);

    localparam int CPB = `IAGC_CLKS_PER_BIT;
    localparam int TW  = $clog2(CPB);

    logic [1:0]    rx_sync;
    logic          busy;
    logic [TW-1:0] tick;
    logic [3:0]    bit_idx;     // 0 is the start bit and 9 the stop bit.
    logic [7:0]    shift;

    assign o_cmd = shift;

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rx_sync <= 2'b11;
            busy    <= 1'b0;
            tick    <= '0;
            bit_idx <= '0;
            shift   <= '0;
            o_valid <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[0], i_rx};
            o_valid <= 1'b0;
            if (!busy) begin
                if (!rx_sync[1]) begin
                    busy    <= 1'b1;
                    tick    <= TW'(CPB / 2 - 1);    // first look lands mid start bit.
                    bit_idx <= '0;
                end
            end else if (tick != '0) begin
                tick <= tick - 1'b1;
            end else begin
                tick    <= TW'(CPB - 1);
                bit_idx <= bit_idx + 1'b1;
                if (bit_idx == 4'd0) begin
                    busy <= !rx_sync[1];            // a short glitch is not a start bit.
                end else if (bit_idx == 4'd9) begin
                    busy    <= 1'b0;
                    o_valid <= rx_sync[1];          // a low stop bit drops the frame.
                end else begin
                    shift <= {rx_sync[1], shift[7:1]};   // lsb arrives first.
                end
            end
        end
    end

endmodule

//--- uart/uart_tx.sv
`timescale 1ns/1ns

`include "iagc_settings.svh"

module uart_tx (
    input  logic        i_clock,
    input  logic        i_arst_n,
    input  logic        i_start,
    input  logic [7:0]  i_data,
    output logic        o_tx,
    output logic        o_ready
);

    localparam int CPB = `IAGC_CLKS_PER_BIT;
    localparam int TW  = $clog2(CPB);

    logic [9:0]    frame;
    logic [TW-1:0] tick;
    logic [3:0]    bits_left;

    assign o_tx    = frame[0];
    assign o_ready = (bits_left == 4'd0);

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            frame     <= '1;        // line idles high.
            tick      <= '0;
            bits_left <= '0;
        end else if (o_ready) begin
            if (i_start) begin
                frame     <= {1'b1, i_data, 1'b0};
                bits_left <= 4'd10;
                tick      <= TW'(CPB - 1);
            end
        end else if (tick == '0) begin
            frame     <= {1'b1, frame[9:1]};    // ones fill in behind the stop bit.
            bits_left <= bits_left - 1'b1;
            tick      <= TW'(CPB - 1);
        end else begin
            tick <= tick - 1'b1;
        end
    end

endmodule

//--- source/iagc_control.sv
`timescale 1ns/1ns

`include "iagc_settings.svh"

module iagc_control (
    input  logic                    i_clock,
    input  logic                    i_arst_n,
    input  iagc_pkg::cmd_t          i_cmd,
    input  logic                    i_cmd_valid,
    input  logic                    i_capture_done,
    input  logic                    i_dump_done,
    input  logic                    i_log_done,
    output iagc_pkg::iagc_cfg_t     o_cfg,
    output iagc_pkg::iagc_state_t   o_state
);
    import iagc_pkg::*;

    localparam int LW = `IAGC_ADDR_W + 1;

    // Capture length is 4 x (p + 1) words.
    function automatic logic [LW-1:0] words_of(input logic [3:0] p);
        return (LW'(p) + LW'(1)) << 2;
    endfunction

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_state         <= ST_IDLE;
            o_cfg.decimator <= 4'(`IAGC_DEF_DECIMATOR);
            o_cfg.length    <= words_of(4'(`IAGC_DEF_MEM_PARAM));
        end else begin
            case (o_state)
                ST_IDLE: begin
                    if (i_cmd_valid) begin
                        case (i_cmd.op)
                            OP_SET_DECIMATOR: o_cfg.decimator <= i_cmd.param;
                            OP_SET_LENGTH:    o_cfg.length    <= words_of(i_cmd.param);
                            OP_CAPTURE:       o_state         <= ST_CAPTURE;
                            OP_DUMP:          o_state         <= ST_DUMP;
                            OP_LOG:           o_state         <= ST_LOG;
                            default: ;      // unknown opcodes change nothing.
                        endcase
                    end
                end
                ST_CAPTURE: begin
                    if (i_capture_done) begin
                        o_state <= ST_IDLE;
                    end
                end
                ST_DUMP: begin
                    if (i_dump_done) begin
                        o_state <= ST_IDLE;
                    end
                end
                ST_LOG: begin
                    if (i_log_done) begin
                        o_state <= ST_IDLE;
                    end
                end
                default: o_state <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- source/sample_store.sv
`timescale 1ns/1ns

`include "iagc_settings.svh"

module sample_store (
    input  logic                        i_clock,
    input  logic                        i_arst_n,
    input  iagc_pkg::iagc_state_t       i_state,
    input  iagc_pkg::iagc_cfg_t         i_cfg,
    input  logic [`IAGC_ADC_W-1:0]      i_adc_ch1,
    input  logic [`IAGC_ADC_W-1:0]      i_adc_ch2,
    input  logic [`IAGC_ADDR_W-1:0]     i_raddr,
    output iagc_pkg::sample_pair_t      o_rdata,
    output logic                        o_sample,
    output iagc_pkg::sample_pair_t      o_pair,
    output logic                        o_done
);
    import iagc_pkg::*;

    localparam int AW = `IAGC_ADC_W;
    localparam int SW = `IAGC_SAMPLE_W;

    logic [3:0]             dec_cnt;
    logic [`IAGC_ADDR_W:0]  waddr;
    logic                   wr_en;
    sample_pair_t           mem [`IAGC_MEM_DEPTH];

    function automatic logic [SW-1:0] widen(input logic [AW-1:0] raw);
        return {{(SW - AW){raw[AW-1]}}, raw};
    endfunction

    assign o_pair.ref_sample = widen(i_adc_ch1);
    assign o_pair.err_sample = widen(i_adc_ch2);

    // writes stop once the configured length is reached.
    assign wr_en = (i_state == ST_CAPTURE) && o_sample && (waddr != i_cfg.length);

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            dec_cnt  <= '0;
            o_sample <= 1'b0;
        end else if (i_state != ST_CAPTURE && i_state != ST_LOG) begin
            dec_cnt  <= '0;
            o_sample <= 1'b0;
        end else if (dec_cnt == i_cfg.decimator) begin
            dec_cnt  <= '0;
            o_sample <= 1'b1;           // one strobe every decimator + 1 clocks.
        end else begin
            dec_cnt  <= dec_cnt + 1'b1;
            o_sample <= 1'b0;
        end
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            waddr  <= '0;
            o_done <= 1'b0;
        end else begin
            o_done <= wr_en && (waddr + 1'b1 == i_cfg.length);
            if (i_state != ST_CAPTURE) begin
                waddr <= '0;
            end else if (wr_en) begin
                waddr <= waddr + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (wr_en) begin
            mem[waddr[`IAGC_ADDR_W-1:0]] <= o_pair;
        end
        o_rdata <= mem[i_raddr];
    end

endmodule

//--- source/dump_unit.sv
`timescale 1ns/1ns

`include "iagc_settings.svh"

module dump_unit (
    input  logic                        i_clock,
    input  logic                        i_arst_n,
    input  iagc_pkg::iagc_state_t       i_state,
    input  logic [`IAGC_ADDR_W:0]       i_length,
    input  iagc_pkg::sample_pair_t      i_rdata,
    input  logic                        i_taken,
    output logic [`IAGC_ADDR_W-1:0]     o_raddr,
    output iagc_pkg::tx_req_t           o_req,
    output logic                        o_done
);
    import iagc_pkg::*;

    typedef enum logic [1:0] {D_IDLE, D_FETCH, D_SEND, D_END} dump_st_t;

    dump_st_t               st;
    logic [`IAGC_ADDR_W:0]  word;
    logic [1:0]             byte_idx;
    logic [3:0][7:0]        rd_bytes;

    assign rd_bytes    = i_rdata;
    assign o_raddr     = word[`IAGC_ADDR_W-1:0];
    assign o_req.valid = (st == D_SEND);
    assign o_req.data  = rd_bytes[~byte_idx];  // index 0 picks the reference high byte.

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            st       <= D_IDLE;
            word     <= '0;
            byte_idx <= '0;
            o_done   <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (st)
                D_IDLE: begin
                    word     <= '0;
                    byte_idx <= '0;
                    if (i_state == ST_DUMP) begin
                        st <= D_FETCH;
                    end
                end
                D_FETCH: st <= D_SEND;      // the memory read port is registered.
                D_SEND: begin
                    if (i_taken) begin
                        byte_idx <= byte_idx + 1'b1;
                        if (byte_idx == 2'd3) begin
                            word <= word + 1'b1;
                            st   <= (word + 1'b1 == i_length) ? D_END : D_FETCH;
                            o_done <= (word + 1'b1 == i_length);
                        end
                    end
                end
                D_END: begin
                    if (i_state != ST_DUMP) begin
                        st <= D_IDLE;
                    end
                end
                default: st <= D_IDLE;
            endcase
        end
    end

endmodule

//--- source/amplitude_logger.sv
`timescale 1ns/1ns

`include "iagc_settings.svh"

module amplitude_logger (
    input  logic                        i_clock,
    input  logic                        i_arst_n,
    input  iagc_pkg::iagc_state_t       i_state,
    input  logic                        i_sample,
    input  iagc_pkg::sample_pair_t      i_pair,
    input  logic                        i_taken,
    output iagc_pkg::tx_req_t           o_req,
    output logic                        o_done
);
    import iagc_pkg::*;

    localparam int WIN = `IAGC_AMP_WINDOW;
    localparam logic signed [`IAGC_SAMPLE_W-1:0] MOST_NEG =
        {1'b1, {(`IAGC_SAMPLE_W - 1){1'b0}}};

    typedef enum logic [1:0] {L_IDLE, L_TRACK, L_SEND, L_END} log_st_t;

    log_st_t                st;
    sample_pair_t           peak;
    logic [$clog2(WIN)-1:0] win_cnt;
    logic [1:0]             byte_idx;
    logic [3:0][7:0]        peak_bytes;

    assign peak_bytes  = peak;
    assign o_req.valid = (st == L_SEND);
    assign o_req.data  = peak_bytes[~byte_idx];    // same byte order as a dump word.

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            st       <= L_IDLE;
            peak     <= '{MOST_NEG, MOST_NEG};
            win_cnt  <= '0;
            byte_idx <= '0;
            o_done   <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (st)
                L_IDLE: begin
                    peak     <= '{MOST_NEG, MOST_NEG};     // any sample beats this.
                    win_cnt  <= '0;
                    byte_idx <= '0;
                    if (i_state == ST_LOG) begin
                        st <= L_TRACK;
                    end
                end
                L_TRACK: begin
                    if (i_sample) begin
                        if (i_pair.ref_sample > peak.ref_sample) begin
                            peak.ref_sample <= i_pair.ref_sample;
                        end
                        if (i_pair.err_sample > peak.err_sample) begin
                            peak.err_sample <= i_pair.err_sample;
                        end
                        win_cnt <= win_cnt + 1'b1;
                        if (win_cnt == WIN - 1) begin
                            st <= L_SEND;
                        end
                    end
                end
                L_SEND: begin
                    if (i_taken) begin
                        byte_idx <= byte_idx + 1'b1;
                        if (byte_idx == 2'd3) begin
                            st     <= L_END;
                            o_done <= 1'b1;
                        end
                    end
                end
                L_END: begin
                    if (i_state != ST_LOG) begin
                        st <= L_IDLE;
                    end
                end
                default: st <= L_IDLE;
            endcase
        end
    end

endmodule

//--- source/tx_arbiter.sv
`timescale 1ns/1ns

module tx_arbiter (
    input  logic                i_clock,
    input  logic                i_arst_n,
    input  iagc_pkg::tx_req_t   i_dump_req,
    input  iagc_pkg::tx_req_t   i_log_req,
    input  logic                i_tx_ready,
    output logic                o_dump_taken,
    output logic                o_log_taken,
    output logic                o_tx_start,
    output logic [7:0]          o_tx_data
);

    logic free;
    logic grant_dump;
    logic grant_log;

    // The transmitter still shows ready in the cycle of the start pulse,
    // so no grant is given in that cycle.
    assign free       = i_tx_ready && !o_tx_start;
    assign grant_dump = free && i_dump_req.valid;
    assign grant_log  = free && !i_dump_req.valid && i_log_req.valid;  // dump unit wins.

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_tx_start   <= 1'b0;
            o_dump_taken <= 1'b0;
            o_log_taken  <= 1'b0;
        end else begin
            o_tx_start   <= grant_dump || grant_log;
            o_dump_taken <= grant_dump;
            o_log_taken  <= grant_log;
        end
    end

    always_ff @(posedge i_clock) begin
        if (grant_dump) begin
            o_tx_data <= i_dump_req.data;
        end else if (grant_log) begin
            o_tx_data <= i_log_req.data;
        end
    end

endmodule

//--- source/iagc_top.sv
`timescale 1ns/1ns

`include "iagc_settings.svh"

module iagc_top (
    input  logic                    i_clock,
    input  logic                    i_arst_n,
    input  logic                    i_rx,
    output logic                    o_tx,
    input  logic [`IAGC_ADC_W-1:0]  i_adc_ch1,
    input  logic [`IAGC_ADC_W-1:0]  i_adc_ch2,
    output iagc_pkg::iagc_state_t   o_status
);
    import iagc_pkg::*;

    cmd_t                     rx_cmd;
    logic                     rx_valid;
    iagc_cfg_t                cfg;
    logic                     capture_done;
    logic                     dump_done;
    logic                     log_done;
    logic                     sample;
    sample_pair_t             pair;
    sample_pair_t             rdata;
    logic [`IAGC_ADDR_W-1:0]  raddr;
    tx_req_t                  dump_req;
    tx_req_t                  log_req;
    logic                     dump_taken;
    logic                     log_taken;
    logic                     tx_start;
    logic [7:0]               tx_data;
    logic                     tx_ready;

    uart_rx u_uart_rx (
        .i_clock    ( i_clock   ),
        .i_arst_n   ( i_arst_n  ),
        .i_rx       ( i_rx      ),
        .o_cmd      ( rx_cmd    ),
        .o_valid    ( rx_valid  )
    );

    iagc_control u_iagc_control (
        .i_clock        ( i_clock       ),
        .i_arst_n       ( i_arst_n      ),
        .i_cmd          ( rx_cmd        ),
        .i_cmd_valid    ( rx_valid      ),
        .i_capture_done ( capture_done  ),
        .i_dump_done    ( dump_done     ),
        .i_log_done     ( log_done      ),
        .o_cfg          ( cfg           ),
        .o_state        ( o_status      )
    );

    sample_store u_sample_store (
        .i_clock    ( i_clock       ),
        .i_arst_n   ( i_arst_n      ),
        .i_state    ( o_status      ),
        .i_cfg      ( cfg           ),
        .i_adc_ch1  ( i_adc_ch1     ),
        .i_adc_ch2  ( i_adc_ch2     ),
        .i_raddr    ( raddr         ),
        .o_rdata    ( rdata         ),
        .o_sample   ( sample        ),
        .o_pair     ( pair          ),
        .o_done     ( capture_done  )
    );

    dump_unit u_dump_unit (
        .i_clock    ( i_clock       ),
        .i_arst_n   ( i_arst_n      ),
        .i_state    ( o_status      ),
        .i_length   ( cfg.length    ),
        .i_rdata    ( rdata         ),
        .i_taken    ( dump_taken    ),
        .o_raddr    ( raddr         ),
        .o_req      ( dump_req      ),
        .o_done     ( dump_done     )
    );

    amplitude_logger u_amplitude_logger (
        .i_clock    ( i_clock   ),
        .i_arst_n   ( i_arst_n  ),
        .i_state    ( o_status  ),
        .i_sample   ( sample    ),
        .i_pair     ( pair      ),
        .i_taken    ( log_taken ),
        .o_req      ( log_req   ),
        .o_done     ( log_done  )
    );

    tx_arbiter u_tx_arbiter (
        .i_clock        ( i_clock       ),
        .i_arst_n       ( i_arst_n      ),
        .i_dump_req     ( dump_req      ),
        .i_log_req      ( log_req       ),
        .i_tx_ready     ( tx_ready      ),
        .o_dump_taken   ( dump_taken    ),
        .o_log_taken    ( log_taken     ),
        .o_tx_start     ( tx_start      ),
        .o_tx_data      ( tx_data       )
    );

    uart_tx u_uart_tx (
        .i_clock    ( i_clock   ),
        .i_arst_n   ( i_arst_n  ),
        .i_start    ( tx_start  ),
        .i_data     ( tx_data   ),
        .o_tx       ( o_tx      ),
        .o_ready    ( tx_ready  )
    );

endmodule

//--- test/iagc_chk.sv
`timescale 1ns/1ns

module iagc_chk (
    input  logic                    i_clock,
    input  logic                    i_arst_n,
    input  logic                    i_tx,
    input  logic                    i_ready,
    input  logic                    i_start,
    input  iagc_pkg::iagc_state_t   i_state
);
    import iagc_pkg::*;

    int unsigned fail_count = 0;

    idle_high: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_ready |-> i_tx)
        else begin
            fail_count++;
            $error("uart line low while the transmitter is ready");
        end

    start_bit_low: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        $fell(i_ready) |-> !i_tx)   // first bit of a frame.
        else begin
            fail_count++;
            $error("frame began without a low start bit");
        end

    stop_bit_high: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        $rose(i_ready) |-> $past(i_tx))     // last bit shown before ready returns.
        else begin
            fail_count++;
            $error("frame ended with a low stop bit");
        end

    start_only_ready: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_start |-> i_ready)
        else begin
            fail_count++;
            $error("start pulse while a frame was still being sent");
        end

    reset_state: assert property (@(posedge i_clock)
        $rose(i_arst_n) |-> (i_state == ST_IDLE) && i_tx)
        else begin
            fail_count++;
            $error("state or uart line wrong when reset was released");
        end

endmodule

bind iagc_top iagc_chk u_chk (
    .i_clock    ( i_clock   ),
    .i_arst_n   ( i_arst_n  ),
    .i_tx       ( o_tx      ),
    .i_ready    ( tx_ready  ),
    .i_start    ( tx_start  ),
    .i_state    ( o_status  )
);

//--- test/iagc_tb.sv
`timescale 1ns/1ns

`include "iagc_settings.svh"

module iagc_tb;
    import iagc_pkg::*;

    localparam int CPB         = `IAGC_CLKS_PER_BIT;
    localparam int LEN_PARAM   = 2;
    localparam int DUMP_BYTES  = 16 * (LEN_PARAM + 1);
    localparam int NEW_DEC     = 5;
    localparam int FRAME_CLKS  = 10 * CPB;
    localparam int FRAMES      = 7 + DUMP_BYTES + 4;   // seven commands in, dump and log out.
    localparam int WATCHDOG_NS = (FRAMES + 20) * FRAME_CLKS * 8;

    logic                   clock;
    logic                   arst_n;
    logic                   rx;
    logic                   tx;
    logic [`IAGC_ADC_W-1:0] adc_ch1;
    logic [`IAGC_ADC_W-1:0] adc_ch2;
    iagc_state_t            status;
    logic [7:0]             rx_q [$];
    int                     errors = 0;
    int                     seed = 32'ha000;

    iagc_top DUT (
        .i_clock    ( clock     ),
        .i_arst_n   ( arst_n    ),
        .i_rx       ( rx        ),
        .o_tx       ( tx        ),
        .i_adc_ch1  ( adc_ch1   ),
        .i_adc_ch2  ( adc_ch2   ),
        .o_status   ( status    )
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // a raw word with its top bit set stands for raw minus 2^14.
    function automatic logic [15:0] as_sample(input logic [`IAGC_ADC_W-1:0] raw);
        if (raw[`IAGC_ADC_W-1]) begin
            return 16'(int'(raw) - (1 << `IAGC_ADC_W));
        end
        return 16'(raw);
    endfunction

    task automatic check(input logic ok, input string msg);
        assert (ok) else begin
            errors++;
            $display("[ERROR] %0t ns: %s", $time, msg);
        end
    endtask

    task automatic send_cmd(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(negedge clock);
            rx = frame[i];
            repeat (CPB - 1) @(negedge clock);
        end
    endtask

    task automatic wait_status(input iagc_state_t target, input int limit);
        int n;
        n = 0;
        while (status !== target && n < limit) begin
            @(negedge clock);
            n++;
        end
        assert (status === target) else begin
            errors++;
            $display("status did not reach %s within %0d clocks", target.name(), limit);
        end
    endtask

    task automatic wait_bytes(input int count);
        int n;
        n = 0;
        while (rx_q.size() < count && n < (count + 2) * FRAME_CLKS) begin
            @(negedge clock);
            n++;
        end
        repeat (2 * FRAME_CLKS) @(negedge clock);     // an extra frame would land in here.
        check(rx_q.size() == count,
              $sformatf("%0d bytes received, expected %0d", rx_q.size(), count));
    endtask

    task automatic check_group(input int base, input logic [15:0] ref_exp,
                               input logic [15:0] err_exp, input string what);
        check(rx_q[base] === ref_exp[15:8],
              $sformatf("%s ref high %h, expected %h", what, rx_q[base], ref_exp[15:8]));
        check(rx_q[base + 1] === ref_exp[7:0],
              $sformatf("%s ref low %h, expected %h", what, rx_q[base + 1], ref_exp[7:0]));
        check(rx_q[base + 2] === err_exp[15:8],
              $sformatf("%s err high %h, expected %h", what, rx_q[base + 2], err_exp[15:8]));
        check(rx_q[base + 3] === err_exp[7:0],
              $sformatf("%s err low %h, expected %h", what, rx_q[base + 3], err_exp[7:0]));
    endtask

    // host side receiver, sampling o_tx at mid-bit on falling edges.
    initial begin : tx_monitor
        logic [7:0] b;
        forever begin
            @(negedge clock);
            if (arst_n && tx === 1'b0) begin
                repeat (CPB / 2) @(negedge clock);
                check(tx === 1'b0, "start bit on o_tx did not stay low");
                for (int i = 0; i < 8; i++) begin
                    repeat (CPB) @(negedge clock);
                    b[i] = tx;
                end
                repeat (CPB) @(negedge clock);
                check(tx === 1'b1, "stop bit on o_tx was low");
                rx_q.push_back(b);
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin : main
        int chk_fails;
        arst_n  = 1'b0;
        rx      = 1'b1;
        adc_ch1 = '0;
        adc_ch2 = '0;
        repeat (10) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;

        check(status === ST_IDLE, "status not idle after reset");
        check(tx === 1'b1, "o_tx not high after reset");
        wait_bytes(0);

        send_cmd(8'h00);
        repeat (4) @(negedge clock);
        check(status === ST_IDLE, "opcode 0 changed the state");
        send_cmd(8'h9a);
        repeat (4) @(negedge clock);
        check(status === ST_IDLE, "opcode 9 changed the state");
        wait_bytes(0);

        // negative reference and positive error held through the capture.
        adc_ch1     = 14'($random(seed));
        adc_ch1[13] = 1'b1;
        adc_ch2     = 14'($random(seed));
        adc_ch2[13] = 1'b0;
        send_cmd({OP_SET_LENGTH, 4'(LEN_PARAM)});
        send_cmd({OP_CAPTURE, 4'h0});
        wait_status(ST_CAPTURE, 8);
        wait_status(ST_IDLE, 2000);
        rx_q.delete();
        send_cmd({OP_DUMP, 4'h0});
        wait_status(ST_DUMP, 8);
        wait_status(ST_IDLE, (DUMP_BYTES + 2) * FRAME_CLKS);
        wait_bytes(DUMP_BYTES);
        if (rx_q.size() == DUMP_BYTES) begin
            for (int w = 0; w < DUMP_BYTES / 4; w++) begin
                check_group(4 * w, as_sample(adc_ch1), as_sample(adc_ch2),
                            $sformatf("dump word %0d", w));
            end
        end

        rx_q.delete();
        send_cmd({OP_SET_DECIMATOR, 4'(NEW_DEC)});
        adc_ch1 = 14'($random(seed));
        adc_ch2 = 14'($random(seed));
        send_cmd({OP_LOG, 4'h0});
        wait_status(ST_LOG, 8);
        wait_status(ST_IDLE, `IAGC_AMP_WINDOW * (NEW_DEC + 1) + 6 * FRAME_CLKS);
        wait_bytes(4);
        if (rx_q.size() == 4) begin
            check_group(0, as_sample(adc_ch1), as_sample(adc_ch2), "log report");
        end

        chk_fails = DUT.u_chk.fail_count;
        $display("failed checks: %0d, failed assertions: %0d", errors, chk_fails);
        if (errors == 0 && chk_fails == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+common
common/iagc_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
source/iagc_control.sv
source/sample_store.sv
source/dump_unit.sv
source/amplitude_logger.sv
source/tx_arbiter.sv
source/iagc_top.sv
test/iagc_chk.sv
test/iagc_tb.sv
